/* rtl/eth_field_pkg.sv */
package eth_field_pkg;

  // Receive beat and header field widths
  localparam int WORD_W = 64;
  localparam int IP_W   = 32;
  localparam int PORT_W = 16;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [IP_W-1:0]   ip_t;
  typedef logic [PORT_W-1:0] port_t;

  // Header beat layout, low bit of each field
  //   63..32 source IP
  //   31..16 source port
  //   15..0  destination port
  localparam int HDR_SRC_IP_LSB   = 32;
  localparam int HDR_SRC_PORT_LSB = 16;
  localparam int HDR_DST_PORT_LSB = 0;

endpackage

/* rtl/rx_filter_pkg.sv */
package rx_filter_pkg;

  // Number of destination port lanes
  localparam int NUM_LANES  = 4;
  localparam int LANE_IDX_W = $clog2(NUM_LANES);

  typedef logic [LANE_IDX_W-1:0] lane_idx_t;

  // Cycles led_rx stays lit after a delivered frame end
  localparam int LED_STRETCH = 16;
  localparam int LED_CNT_W   = $clog2(LED_STRETCH + 1);

  typedef logic [LED_CNT_W-1:0] led_cnt_t;

  // Position within a frame
  typedef enum logic [0:0] {
    EXPECT_HDR,
    IN_PAYLOAD
  } parse_state_t;

endpackage

/* rtl/rx_hdr_if.sv */
`timescale 1ns/1ps

interface rx_hdr_if;

  // One pulse per frame that carries payload
  logic                 hdr_valid;
  eth_field_pkg::ip_t   src_ip;
  eth_field_pkg::port_t src_port;
  eth_field_pkg::port_t dst_port;

  modport parser (
    output hdr_valid,
    output src_ip,
    output src_port,
    output dst_port
  );

  // Lanes only compare the destination port
  modport lane (
    input hdr_valid,
    input dst_port
  );

  modport merge (
    input hdr_valid,
    input src_ip,
    input src_port
  );

endinterface

/* rtl/rx_beat_if.sv */
`timescale 1ns/1ps

interface rx_beat_if;

  logic                 beat_valid;
  eth_field_pkg::word_t data;
  logic                 eof;
  // Only set together with eof
  logic                 bad;

  modport parser (
    output beat_valid,
    output data,
    output eof,
    output bad
  );

  modport merge (
    input beat_valid,
    input data,
    input eof,
    input bad
  );

endinterface

/* rtl/rx_header_parser.sv */
`timescale 1ns/1ps

module rx_header_parser (
  input  logic                                clk,
  input  logic                                mac_resetRR,
  input  logic                                in_valid,
  input  eth_field_pkg::word_t                in_data,
  input  logic                                in_end_of_frame,
  input  logic                                in_bad_frame,
  input  logic                                cfg_wr,
  input  rx_filter_pkg::lane_idx_t            cfg_lane,
  rx_hdr_if.parser                            hdr,
  rx_beat_if.parser                           beat,
  output logic [rx_filter_pkg::NUM_LANES-1:0] cfg_sel
);

  rx_filter_pkg::parse_state_t state;

  logic hdr_beat;
  logic pay_beat;

  assign hdr_beat = in_valid && (state == rx_filter_pkg::EXPECT_HDR);
  assign pay_beat = in_valid && (state == rx_filter_pkg::IN_PAYLOAD);

  // First valid beat of a frame is the header
  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      state <= rx_filter_pkg::EXPECT_HDR;
    end else if (in_valid) begin
      case (state)
        rx_filter_pkg::EXPECT_HDR: begin
          // Header-only frame stays here and is dropped
          if (!in_end_of_frame) begin
            state <= rx_filter_pkg::IN_PAYLOAD;
          end
        end
        rx_filter_pkg::IN_PAYLOAD: begin
          if (in_end_of_frame) begin
            state <= rx_filter_pkg::EXPECT_HDR;
          end
        end
        default: begin
          state <= rx_filter_pkg::EXPECT_HDR;
        end
      endcase
    end
  end

  // Strobes toward lanes and merge
  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      hdr.hdr_valid   <= 1'b0;
      beat.beat_valid <= 1'b0;
    end else begin
      hdr.hdr_valid   <= hdr_beat && !in_end_of_frame;
      beat.beat_valid <= pay_beat;
    end
  end

  // Header fields
  always_ff @(posedge clk) begin
    if (hdr_beat) begin
      hdr.src_ip   <= in_data[eth_field_pkg::HDR_SRC_IP_LSB +: eth_field_pkg::IP_W];
      hdr.src_port <= in_data[eth_field_pkg::HDR_SRC_PORT_LSB +: eth_field_pkg::PORT_W];
      hdr.dst_port <= in_data[eth_field_pkg::HDR_DST_PORT_LSB +: eth_field_pkg::PORT_W];
    end
  end

  // Payload beat, bad flag kept only on the last beat
  always_ff @(posedge clk) begin
    if (pay_beat) begin
      beat.data <= in_data;
      beat.eof  <= in_end_of_frame;
      beat.bad  <= in_bad_frame && in_end_of_frame;
    end
  end

  // One-hot configuration write strobe
  always_comb begin
    cfg_sel = '0;
    if (cfg_wr) begin
      cfg_sel[cfg_lane] = 1'b1;
    end
  end

  // A forwarded beat that is not the last keeps the frame open
  a_beat_in_frame: assert property (
    @(posedge clk) disable iff (mac_resetRR)
    beat.beat_valid && !beat.eof |-> state == rx_filter_pkg::IN_PAYLOAD
  ) else $error("payload beat forwarded outside a frame");

endmodule

/* rtl/udp_port_lane.sv */
`timescale 1ns/1ps

module udp_port_lane (
  input  logic                 clk,
  input  logic                 mac_resetRR,
  input  logic                 cfg_sel,
  input  eth_field_pkg::port_t cfg_port,
  input  logic                 cfg_enable,
  rx_hdr_if.lane               hdr,
  output logic                 match
);

  eth_field_pkg::port_t port_q;
  logic                 en_q;
  logic                 port_hit;

  assign port_hit = (hdr.dst_port == port_q);

  // Programmed destination port
  always_ff @(posedge clk) begin
    if (cfg_sel) begin
      port_q <= cfg_port;
    end
  end

  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      en_q <= 1'b0;
    end else if (cfg_sel) begin
      en_q <= cfg_enable;
    end
  end

  // Decision per header, held for the frame
  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      match <= 1'b0;
    end else begin
      if (hdr.hdr_valid) begin
        match <= en_q && port_hit;
      end
      // Disabling the lane also drops the frame in progress
      if (cfg_sel && !cfg_enable) begin
        match <= 1'b0;
      end
    end
  end

  a_no_match_disabled: assert property (
    @(posedge clk) disable iff (mac_resetRR)
    !en_q |-> !match
  ) else $error("lane matches while disabled");

endmodule

/* rtl/rx_lane_merge.sv */
`timescale 1ns/1ps

module rx_lane_merge (
  input  logic                               clk,
  input  logic                               mac_resetRR,
  rx_hdr_if.merge                            hdr,
  rx_beat_if.merge                           beat,
  input  logic [rx_filter_pkg::NUM_LANES-1:0] match,
  output logic                               rx_valid,
  output eth_field_pkg::word_t               rx_data,
  output logic                               rx_end_of_frame,
  output logic                               rx_bad_frame,
  output eth_field_pkg::ip_t                 rx_source_ip,
  output eth_field_pkg::port_t               rx_source_port,
  output rx_filter_pkg::lane_idx_t           rx_lane,
  output logic                               led_rx
);

  rx_filter_pkg::parse_state_t frame_state;
  eth_field_pkg::ip_t          src_ip_q;
  eth_field_pkg::port_t        src_port_q;
  rx_filter_pkg::lane_idx_t    win_lane;
  rx_filter_pkg::led_cnt_t     led_cnt;
  logic                        fwd;

  // Lowest matching lane wins
  always_comb begin
    win_lane = '0;
    for (int i = rx_filter_pkg::NUM_LANES - 1; i >= 0; i--) begin
      if (match[i]) begin
        win_lane = rx_filter_pkg::lane_idx_t'(i);
      end
    end
  end

  assign fwd = beat.beat_valid && (|match) && (frame_state == rx_filter_pkg::IN_PAYLOAD);

  // Frame bracket, next header may land on the previous last beat
  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      frame_state <= rx_filter_pkg::EXPECT_HDR;
    end else if (hdr.hdr_valid) begin
      frame_state <= rx_filter_pkg::IN_PAYLOAD;
    end else if (beat.beat_valid && beat.eof) begin
      frame_state <= rx_filter_pkg::EXPECT_HDR;
    end
  end

  // Source fields held for the frame
  always_ff @(posedge clk) begin
    if (hdr.hdr_valid) begin
      src_ip_q   <= hdr.src_ip;
      src_port_q <= hdr.src_port;
    end
  end

  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      rx_valid        <= 1'b0;
      rx_end_of_frame <= 1'b0;
      rx_bad_frame    <= 1'b0;
    end else begin
      rx_valid        <= fwd;
      rx_end_of_frame <= fwd && beat.eof;
      rx_bad_frame    <= fwd && beat.bad;
    end
  end

  // Output payload
  always_ff @(posedge clk) begin
    if (fwd) begin
      rx_data        <= beat.data;
      rx_source_ip   <= src_ip_q;
      rx_source_port <= src_port_q;
      rx_lane        <= win_lane;
    end
  end

  // Activity stretch, reloaded on every delivered frame end
  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      led_cnt <= '0;
    end else if (rx_valid && rx_end_of_frame) begin
      led_cnt <= rx_filter_pkg::led_cnt_t'(rx_filter_pkg::LED_STRETCH);
    end else if (led_cnt != '0) begin
      led_cnt <= led_cnt - 1'b1;
    end
  end

  assign led_rx = (led_cnt != '0);

  a_bad_at_eof: assert property (
    @(posedge clk) disable iff (mac_resetRR)
    rx_bad_frame |-> rx_end_of_frame
  ) else $error("rx_bad_frame without rx_end_of_frame");

endmodule

/* rtl/udp_rx_filter.sv */
`timescale 1ns/1ps

module udp_rx_filter (
  input  logic                     clk,
  input  logic                     mac_resetRR,
  // MAC receive stream
  input  logic                     in_valid,
  input  eth_field_pkg::word_t     in_data,
  input  logic                     in_end_of_frame,
  input  logic                     in_bad_frame,
  // Lane configuration write
  input  logic                     cfg_wr,
  input  rx_filter_pkg::lane_idx_t cfg_lane,
  input  eth_field_pkg::port_t     cfg_port,
  input  logic                     cfg_enable,
  // Application side
  output logic                     rx_valid,
  output eth_field_pkg::word_t     rx_data,
  output logic                     rx_end_of_frame,
  output logic                     rx_bad_frame,
  output eth_field_pkg::ip_t       rx_source_ip,
  output eth_field_pkg::port_t     rx_source_port,
  output rx_filter_pkg::lane_idx_t rx_lane,
  output logic                     led_rx
);

  logic [rx_filter_pkg::NUM_LANES-1:0] cfg_sel;
  logic [rx_filter_pkg::NUM_LANES-1:0] lane_match;

  rx_hdr_if  hdr_bus ();
  rx_beat_if beat_bus ();

  rx_header_parser u_parser (
    .clk             (clk),
    .mac_resetRR     (mac_resetRR),
    .in_valid        (in_valid),
    .in_data         (in_data),
    .in_end_of_frame (in_end_of_frame),
    .in_bad_frame    (in_bad_frame),
    .cfg_wr          (cfg_wr),
    .cfg_lane        (cfg_lane),
    .hdr             (hdr_bus.parser),
    .beat            (beat_bus.parser),
    .cfg_sel         (cfg_sel)
  );

  // One filter per destination port
  for (genvar i = 0; i < rx_filter_pkg::NUM_LANES; i++) begin : g_lane
    udp_port_lane u_lane (
      .clk         (clk),
      .mac_resetRR (mac_resetRR),
      .cfg_sel     (cfg_sel[i]),
      .cfg_port    (cfg_port),
      .cfg_enable  (cfg_enable),
      .hdr         (hdr_bus.lane),
      .match       (lane_match[i])
    );
  end

  rx_lane_merge u_merge (
    .clk             (clk),
    .mac_resetRR     (mac_resetRR),
    .hdr             (hdr_bus.merge),
    .beat            (beat_bus.merge),
    .match           (lane_match),
    .rx_valid        (rx_valid),
    .rx_data         (rx_data),
    .rx_end_of_frame (rx_end_of_frame),
    .rx_bad_frame    (rx_bad_frame),
    .rx_source_ip    (rx_source_ip),
    .rx_source_port  (rx_source_port),
    .rx_lane         (rx_lane),
    .led_rx          (led_rx)
  );

endmodule

/* testbench/tb_udp_rx_filter.sv */
`timescale 1ns/1ps

module tb_udp_rx_filter;

  localparam int CLK_PERIOD = 20;
  localparam int NUM_FRAMES = 60;
  localparam int NUM_PHASES = 3;
  localparam int MAX_BEATS  = 6;
  localparam int MAX_GAP    = 3;
  // Observed one edge after the second output cycle
  localparam int OUT_DELAY  = 3;
  localparam int LANES      = rx_filter_pkg::NUM_LANES;
  localparam int PW         = eth_field_pkg::PORT_W;

  typedef struct packed {
    eth_field_pkg::word_t data;
    logic                 eof;
    logic                 bad;
    eth_field_pkg::ip_t   ip;
    eth_field_pkg::port_t port;
    int                   lane;
    int                   cyc;
  } exp_beat_t;

  logic                     clk;
  logic                     mac_resetRR;
  logic                     in_valid;
  eth_field_pkg::word_t     in_data;
  logic                     in_end_of_frame;
  logic                     in_bad_frame;
  logic                     cfg_wr;
  rx_filter_pkg::lane_idx_t cfg_lane;
  eth_field_pkg::port_t     cfg_port;
  logic                     cfg_enable;
  logic                     rx_valid;
  eth_field_pkg::word_t     rx_data;
  logic                     rx_end_of_frame;
  logic                     rx_bad_frame;
  eth_field_pkg::ip_t       rx_source_ip;
  eth_field_pkg::port_t     rx_source_port;
  rx_filter_pkg::lane_idx_t rx_lane;
  logic                     led_rx;

  integer                seed = 32'h697a_b857;
  int                    cyc = 0;
  int                    delivered = 0;
  exp_beat_t             exp_q[$];
  // Testbench copy of the lane configuration
  logic [LANES-1:0]      ref_en;
  logic [LANES*PW-1:0]   ref_ports;
  eth_field_pkg::port_t  port_set [5] = '{16'h1000, 16'h2000, 16'h3000, 16'h4000, 16'h5000};

  udp_rx_filter u_dut (
    .clk             (clk),
    .mac_resetRR     (mac_resetRR),
    .in_valid        (in_valid),
    .in_data         (in_data),
    .in_end_of_frame (in_end_of_frame),
    .in_bad_frame    (in_bad_frame),
    .cfg_wr          (cfg_wr),
    .cfg_lane        (cfg_lane),
    .cfg_port        (cfg_port),
    .cfg_enable      (cfg_enable),
    .rx_valid        (rx_valid),
    .rx_data         (rx_data),
    .rx_end_of_frame (rx_end_of_frame),
    .rx_bad_frame    (rx_bad_frame),
    .rx_source_ip    (rx_source_ip),
    .rx_source_port  (rx_source_port),
    .rx_lane         (rx_lane),
    .led_rx          (led_rx)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  // Lowest enabled lane holding the destination port, -1 if dropped
  function automatic int expected_lane(input eth_field_pkg::port_t dst, input int nbeats,
                                       input logic [LANES-1:0] en,
                                       input logic [LANES*PW-1:0] ports);
    int lane;
    lane = -1;
    if (nbeats > 0) begin
      for (int i = 0; i < LANES; i++) begin
        if (lane < 0 && en[i] && ports[i*PW +: PW] == dst) begin
          lane = i;
        end
      end
    end
    return lane;
  endfunction

  task automatic write_cfg(input int lane, input eth_field_pkg::port_t port, input logic en);
    @(posedge clk);
    cfg_wr     <= 1'b1;
    cfg_lane   <= rx_filter_pkg::lane_idx_t'(lane);
    cfg_port   <= port;
    cfg_enable <= en;
    ref_en[lane]             = en;
    ref_ports[lane*PW +: PW] = port;
    @(posedge clk);
    cfg_wr <= 1'b0;
  endtask

  task automatic send_frame(input int nbeats, input eth_field_pkg::port_t dst, input logic bad);
    logic [31:0]          r;
    eth_field_pkg::ip_t   src_ip;
    eth_field_pkg::port_t src_port;
    eth_field_pkg::word_t payload;
    exp_beat_t            e;
    int                   lane;
    logic                 last;
    src_ip   = rand32();
    r        = rand32();
    src_port = r[15:0];
    lane     = expected_lane(dst, nbeats, ref_en, ref_ports);
    @(posedge clk);
    r = rand32();
    in_valid        <= 1'b1;
    in_data         <= {src_ip, src_port, dst};
    in_end_of_frame <= (nbeats == 0);
    in_bad_frame    <= (nbeats == 0) ? bad : r[0];
    for (int b = 0; b < nbeats; b++) begin
      @(posedge clk);
      payload = {rand32(), rand32()};
      r       = rand32();
      last    = (b == nbeats - 1);
      in_data         <= payload;
      in_end_of_frame <= last;
      // Bad flag on earlier beats must be ignored
      in_bad_frame    <= last ? bad : r[0];
      if (lane >= 0) begin
        e.data = payload;
        e.eof  = last;
        e.bad  = last && bad;
        e.ip   = src_ip;
        e.port = src_port;
        e.lane = lane;
        e.cyc  = cyc + OUT_DELAY;
        exp_q.push_back(e);
      end
    end
  endtask

  task automatic run_frames(input int count);
    logic [31:0] r;
    int          gap;
    for (int f = 0; f < count; f++) begin
      r = rand32();
      send_frame(int'(r % (MAX_BEATS + 1)), port_set[rand32() % 5], r[8]);
      r = rand32();
      // Back to back about half of the time
      gap = r[0] ? 0 : int'(r[7:1] % MAX_GAP) + 1;
      repeat (gap) begin
        @(posedge clk);
        in_valid <= 1'b0;
      end
    end
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  // Last beats are due within the output latency
  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < OUT_DELAY + 2) begin
      @(posedge clk);
      waited = waited + 1;
    end
    repeat (4) @(posedge clk);
  endtask

  // Compare every output beat and the LED against the expected stream
  initial begin : compare_outputs
    exp_beat_t e;
    int        led_left;
    logic      reload;
    led_left = 0;
    @(negedge mac_resetRR);
    forever begin
      @(posedge clk);
      reload = 1'b0;
      check_value("led_rx", led_rx, led_left != 0);
      if (rx_valid) begin
        if (exp_q.size() == 0) begin
          $display("At %0t ns a beat came out on rx_valid that no frame should produce",
                   $time);
          abort_run();
        end else begin
          e = exp_q.pop_front();
          check_value("output cycle", cyc, e.cyc);
          check_value("rx_data", rx_data, e.data);
          check_value("rx_end_of_frame", rx_end_of_frame, e.eof);
          check_value("rx_bad_frame", rx_bad_frame, e.bad);
          check_value("rx_source_ip", rx_source_ip, e.ip);
          check_value("rx_source_port", rx_source_port, e.port);
          check_value("rx_lane", rx_lane, e.lane);
          reload    = e.eof;
          delivered = delivered + 1;
        end
      end else if (exp_q.size() != 0) begin
        e = exp_q[0];
        if (e.cyc == cyc) begin
          check_value("rx_valid", rx_valid, 1'b1);
        end
      end
      if (reload) begin
        led_left = rx_filter_pkg::LED_STRETCH;
      end else if (led_left > 0) begin
        led_left = led_left - 1;
      end
    end
  end

  initial begin : watchdog
    #((NUM_PHASES * NUM_FRAMES * (MAX_BEATS + 1 + MAX_GAP) + 400) * CLK_PERIOD);
    $display("Timeout at %0t ns, the stimulus did not finish in time", $time);
    abort_run();
  end

  initial begin : stimulus
    mac_resetRR     = 1'b1;
    in_valid        = 1'b0;
    in_data         = '0;
    in_end_of_frame = 1'b0;
    in_bad_frame    = 1'b0;
    cfg_wr          = 1'b0;
    cfg_lane        = '0;
    cfg_port        = '0;
    cfg_enable      = 1'b0;
    ref_en          = '0;
    ref_ports       = '0;
    repeat (5) @(posedge clk);
    mac_resetRR <= 1'b0;
    repeat (2) @(posedge clk);

    // Lanes 1 and 2 share a port, lane 3 stays off
    write_cfg(0, 16'h1000, 1'b1);
    write_cfg(1, 16'h2000, 1'b1);
    write_cfg(2, 16'h2000, 1'b1);
    write_cfg(3, 16'h3000, 1'b0);
    run_frames(NUM_FRAMES);
    wait_drained();

    // Lane 2 takes over port 0x2000
    write_cfg(1, 16'h2000, 1'b0);
    write_cfg(3, 16'h4000, 1'b1);
    run_frames(NUM_FRAMES);
    wait_drained();

    write_cfg(0, 16'h1000, 1'b0);
    write_cfg(2, 16'h2000, 1'b0);
    write_cfg(1, 16'h3000, 1'b1);
    run_frames(NUM_FRAMES);
    wait_drained();

    // Let the LED run out
    repeat (rx_filter_pkg::LED_STRETCH + 4) @(posedge clk);
    $display("%0d beats delivered", delivered);
    if (exp_q.size() != 0) begin
      $display("%0d expected beats never came out", exp_q.size());
      abort_run();
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

/* src.f */
rtl/eth_field_pkg.sv
rtl/rx_filter_pkg.sv
rtl/rx_hdr_if.sv
rtl/rx_beat_if.sv
rtl/rx_header_parser.sv
rtl/udp_port_lane.sv
rtl/rx_lane_merge.sv
rtl/udp_rx_filter.sv
testbench/tb_udp_rx_filter.sv

/* Bender.yml */
package:
  name: udp_rx_filter

sources:
  - files:
      - rtl/eth_field_pkg.sv
      - rtl/rx_filter_pkg.sv
      - rtl/rx_hdr_if.sv
      - rtl/rx_beat_if.sv
      - rtl/rx_header_parser.sv
      - rtl/udp_port_lane.sv
      - rtl/rx_lane_merge.sv
      - rtl/udp_rx_filter.sv
  - target: test
    files:
      - testbench/tb_udp_rx_filter.sv
